//--- Bender.yml
package:
  name: ctrl_top

sources:
  - verilog/ctrl_pkg.sv
  - verilog/keypad_matrix.sv
  - verilog/trackball_feed.sv
  - verilog/console_switches.sv
  - verilog/port_mux.sv
  - verilog/ctrl_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_ctrl_top.sv

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	localparam int HALF_PERIOD = 20; // 40 ns clock

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// Reset held over 5 rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/tb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top;

	localparam int CLK_PERIOD = 40;
	// Reset, power-up, joystick, keypad, trackball and switch sections
	localparam int RUN_CYCLES = 6 + 5 + 200 + 425 + 820 + 225;
	localparam int MARGIN_CYCLES = 500;
	// Keypad scan codes indexed by row * 3 + col
	localparam logic [107:0] KEY_CODES = {
		ctrl_pkg::SC_EQUAL, ctrl_pkg::SC_0, ctrl_pkg::SC_MINUS, ctrl_pkg::SC_9,
		ctrl_pkg::SC_8, ctrl_pkg::SC_7, ctrl_pkg::SC_6, ctrl_pkg::SC_5,
		ctrl_pkg::SC_4, ctrl_pkg::SC_3, ctrl_pkg::SC_2, ctrl_pkg::SC_1};

	wire clk_sys;
	wire reset;
	wire [7:0] pa_in;
	wire [7:0] pb_in;
	wire [1:0] ilatch;
	wire [3:0] idump;
	ctrl_pkg::joy_t joy_a = '0;
	ctrl_pkg::joy_t joy_b = '0;
	ctrl_pkg::ps2_key_t ps2_key = '0;
	ctrl_pkg::ps2_mouse_t ps2_mouse = '0;
	ctrl_pkg::port_type_e porta_type = ctrl_pkg::PORT_NONE;
	ctrl_pkg::port_type_e portb_type = ctrl_pkg::PORT_NONE;
	logic [7:0] pa_out = '0;
	logic [7:0] pb_out = '0;
	logic pa_read = 1'b0;

	// Model state
	logic [11:0] held = '0; // Keypad keys by row * 3 + col
	logic key_f1 = 1'b0;
	logic key_f2 = 1'b0;
	logic sw_r = 1'b0; // 1 = position B
	logic sw_l = 1'b0;
	logic prev_r = 1'b0;
	logic prev_l = 1'b0;
	logic [7:0] cnt_x = '0;
	logic [7:0] cnt_y = '0;
	logic dir_x = 1'b0;
	logic dir_y = 1'b0;
	logic tog_x = 1'b0;
	logic tog_y = 1'b0;
	logic [3:0] ball = '0;
	logic ball_btn = 1'b0;
	integer seed = 32'hc0e88d2d;
	int settle = 3;
	int errors = 0;
	int checks = 0;

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	ctrl_top u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.i_joy_a      (joy_a),
		.i_joy_b      (joy_b),
		.i_ps2_key    (ps2_key),
		.i_ps2_mouse  (ps2_mouse),
		.i_porta_type (porta_type),
		.i_portb_type (portb_type),
		.i_pa_out     (pa_out),
		.i_pb_out     (pb_out),
		.i_pa_read    (pa_read),
		.o_pa_in      (pa_in),
		.o_pb_in      (pb_in),
		.o_ilatch     (ilatch),
		.o_idump      (idump)
	);

	// Expected {o_pa_in, o_ilatch, o_idump, o_pb_in} from inputs and model state
	function automatic logic [21:0] expected_outputs();
		logic [7:0] pa_exp;
		logic [1:0] latch_exp;
		logic [3:0] dump_exp;
		logic [7:0] pb_exp;
		logic [3:0] rows;
		logic [3:0] nib;
		logic [2:0] sense;
		logic [1:0] dump;
		logic latch;
		logic found;
		ctrl_pkg::port_type_e kind;
		ctrl_pkg::joy_t joy;
		for (int p = 0; p < 2; p++) begin
			kind = (p == 0) ? porta_type : portb_type;
			joy = (p == 0) ? joy_a : joy_b;
			rows = (p == 0) ? pa_out[7:4] : pa_out[3:0];
			if (p == 1 && porta_type == ctrl_pkg::PORT_TRACKBALL &&
					portb_type == ctrl_pkg::PORT_TRACKBALL)
				kind = ctrl_pkg::PORT_JOYSTICK; // Trackball stays on port A
			// Highest held row in a column decides its line
			for (int c = 0; c < 3; c++) begin
				sense[c] = 1'b1;
				found = 1'b0;
				for (int r = 3; r >= 0; r--) begin
					if (!found && held[r * 3 + c]) begin
						sense[c] = rows[r];
						found = 1'b1;
					end
				end
			end
			case (kind)
				ctrl_pkg::PORT_JOYSTICK: begin
					nib = ~{joy[ctrl_pkg::JOY_RIGHT], joy[ctrl_pkg::JOY_LEFT],
						joy[ctrl_pkg::JOY_DOWN], joy[ctrl_pkg::JOY_UP]};
					dump = {joy[ctrl_pkg::JOY_FIRE1], joy[ctrl_pkg::JOY_FIRE2]};
					latch = ~|dump;
				end
				ctrl_pkg::PORT_TRACKBALL: begin
					nib = ball;
					dump = 2'b00;
					latch = ~ball_btn;
				end
				ctrl_pkg::PORT_KEYPAD: begin
					nib = rows;
					dump = sense[1:0];
					latch = sense[2];
				end
				default: begin
					nib = 4'hf;
					dump = 2'b00;
					latch = 1'b1;
				end
			endcase
			pa_exp[(1 - p) * 4 +: 4] = nib;
			latch_exp[p] = latch;
			dump_exp[p * 2 +: 2] = dump;
		end
		pb_exp = {~sw_r, ~sw_l, pb_out[5:4],
			~(joy_a[ctrl_pkg::JOY_PAUSE] | joy_b[ctrl_pkg::JOY_PAUSE]), pb_out[2],
			~(joy_a[ctrl_pkg::JOY_SELECT] | joy_b[ctrl_pkg::JOY_SELECT] | key_f1),
			~(joy_a[ctrl_pkg::JOY_START] | joy_b[ctrl_pkg::JOY_START] | key_f2)};
		return {pa_exp, latch_exp, dump_exp, pb_exp};
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("[ERROR] time %0t ns %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_outputs();
		logic [21:0] expected;
		expected = expected_outputs();
		check_value("o_pa_in", expected[21:14], pa_in);
		check_value("o_ilatch", {6'd0, expected[13:12]}, {6'd0, ilatch});
		check_value("o_idump", {4'd0, expected[11:8]}, {4'd0, idump});
		check_value("o_pb_in", expected[7:0], pb_in);
	endtask

	// Compare on every rising edge outside the settling window
	always @(posedge clk_sys) begin
		if (reset)
			settle = 3;
		else if (settle > 0)
			settle = settle - 1;
		else
			compare_outputs();
	end

	task automatic wait_checked();
		while (settle != 0)
			@(negedge clk_sys);
		@(negedge clk_sys); // One compare at the rising edge between
	endtask

	task automatic drive_joy(input ctrl_pkg::joy_t a, input ctrl_pkg::joy_t b);
		logic now_r;
		logic now_l;
		now_r = a[ctrl_pkg::JOY_DIFF_R] | b[ctrl_pkg::JOY_DIFF_R];
		now_l = a[ctrl_pkg::JOY_DIFF_L] | b[ctrl_pkg::JOY_DIFF_L];
		if (now_r && !prev_r)
			sw_r = ~sw_r;
		if (now_l && !prev_l)
			sw_l = ~sw_l;
		if (now_r != prev_r || now_l != prev_l)
			settle = 3;
		prev_r = now_r;
		prev_l = now_l;
		joy_a = a;
		joy_b = b;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, code};
		for (int k = 0; k < 12; k++)
			if (KEY_CODES[k * 9 +: 9] == code)
				held[k] = pressed;
		if (code == ctrl_pkg::SC_F1)
			key_f1 = pressed;
		if (code == ctrl_pkg::SC_F2)
			key_f2 = pressed;
		settle = 3;
	endtask

	// Magnitudes 0..7 with negative counts sent in one's complement
	task automatic send_packet(input logic [31:0] r);
		logic [7:0] val_x;
		logic [7:0] val_y;
		val_x = r[3] ? ~{5'd0, r[2:0]} : {5'd0, r[2:0]};
		val_y = r[7] ? ~{5'd0, r[6:4]} : {5'd0, r[6:4]};
		ps2_mouse = {~ps2_mouse[24], val_y, val_x, 2'b00, r[7], r[3], 2'b10, r[9:8]};
		cnt_x = {5'd0, r[2:0]};
		cnt_y = {5'd0, r[6:4]};
		dir_x = ~r[3];
		dir_y = r[7];
		ball_btn = |r[9:8];
		settle = 3;
	endtask

	task automatic strobe_read();
		pa_read = 1'b1;
		ball = {tog_y, dir_y, tog_x, dir_x}; // Old toggles go out first
		if (cnt_y != 8'd0) begin
			cnt_y = cnt_y - 8'd1;
			tog_y = ~tog_y;
		end
		if (cnt_x != 8'd0) begin
			cnt_x = cnt_x - 8'd1;
			tog_x = ~tog_x;
		end
		settle = 3;
		@(negedge clk_sys);
		pa_read = 1'b0;
		wait_checked();
	endtask

	initial begin
		int idx;
		int steps;
		wait (!reset);
		@(negedge clk_sys);

		// Power-up state with both ports on keypads
		porta_type = ctrl_pkg::PORT_KEYPAD;
		portb_type = ctrl_pkg::PORT_KEYPAD;
		pa_out = $random(seed);
		settle = 3;
		wait_checked();
		check_value("o_pb_in[7:6]", 8'h03, {6'd0, pb_in[7:6]});
		check_value("o_ilatch", 8'h03, {6'd0, ilatch});
		check_value("o_idump", 8'h0f, {4'd0, idump});

		// Joystick and empty ports with the difficulty bits left out
		repeat (200) begin
			porta_type = ($random(seed) & 1) ? ctrl_pkg::PORT_JOYSTICK : ctrl_pkg::PORT_NONE;
			portb_type = ($random(seed) & 1) ? ctrl_pkg::PORT_JOYSTICK : ctrl_pkg::PORT_NONE;
			drive_joy($random(seed) & ~16'h0c00, $random(seed) & ~16'h0c00);
			@(negedge clk_sys);
		end

		// Keypad matrix against random row outputs
		porta_type = ctrl_pkg::PORT_KEYPAD;
		portb_type = ctrl_pkg::PORT_KEYPAD;
		repeat (60) begin
			idx = $unsigned($random(seed)) % 12;
			pa_out = $random(seed);
			send_key(KEY_CODES[idx * 9 +: 9], ~held[idx]);
			wait_checked();
			@(negedge clk_sys);
		end
		send_key(9'h01c, 1'b1); // Not a keypad key
		wait_checked();
		for (int k = 0; k < 12; k++) begin
			if (held[k]) begin
				send_key(KEY_CODES[k * 9 +: 9], 1'b0);
				wait_checked();
			end
		end

		// Trackball on port A with steps paced by reads
		porta_type = ctrl_pkg::PORT_TRACKBALL;
		portb_type = ctrl_pkg::PORT_JOYSTICK;
		repeat (16) begin
			send_packet($random(seed));
			wait_checked();
			steps = ((cnt_x > cnt_y) ? cnt_x : cnt_y) + 1;
			repeat (steps)
				strobe_read();
		end
		portb_type = ctrl_pkg::PORT_TRACKBALL; // Port B falls back to joystick
		repeat (20) begin
			drive_joy(joy_a, $random(seed) & ~16'h0c00);
			@(negedge clk_sys);
		end

		// Console switches
		porta_type = ctrl_pkg::PORT_JOYSTICK;
		portb_type = ctrl_pkg::PORT_JOYSTICK;
		drive_joy(16'h0800, 16'h0000);
		repeat (8) @(negedge clk_sys); // Held button flips once only
		drive_joy(16'h0000, 16'h0400);
		repeat (8) @(negedge clk_sys);
		drive_joy(16'h0000, 16'h0000);
		wait_checked();
		repeat (40) begin
			drive_joy($random(seed) & 16'h0dc0, $random(seed) & 16'h0dc0);
			pb_out = $random(seed);
			if ($random(seed) & 1)
				send_key(($random(seed) & 1) ? ctrl_pkg::SC_F1 : ctrl_pkg::SC_F2, $random(seed));
			wait_checked();
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
		$display("Timeout: tests did not finish within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/ctrl_pkg.sv
verilog/keypad_matrix.sv
verilog/trackball_feed.sv
verilog/console_switches.sv
verilog/port_mux.sv
verilog/ctrl_top.sv
tb/tb_clock_gen.sv
tb/tb_ctrl_top.sv

//--- verilog/console_switches.sv
`timescale 1ns/1ps
`default_nettype none

module console_switches (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire ctrl_pkg::joy_t       i_joy_a,
	input  wire ctrl_pkg::joy_t       i_joy_b,
	input  wire                       i_key_start,
	input  wire                       i_key_select,
	input  wire ctrl_pkg::riot_port_t i_pb_out,
	output ctrl_pkg::riot_port_t      o_pb_in
);

	logic old_diff_r, old_diff_l;
	logic diff_r, diff_l; // 0 = position A

	wire btn_diff_r = i_joy_a[ctrl_pkg::JOY_DIFF_R] | i_joy_b[ctrl_pkg::JOY_DIFF_R];
	wire btn_diff_l = i_joy_a[ctrl_pkg::JOY_DIFF_L] | i_joy_b[ctrl_pkg::JOY_DIFF_L];
	wire btn_pause = i_joy_a[ctrl_pkg::JOY_PAUSE] | i_joy_b[ctrl_pkg::JOY_PAUSE];
	wire btn_select = i_joy_a[ctrl_pkg::JOY_SELECT] | i_joy_b[ctrl_pkg::JOY_SELECT] |
		i_key_select;
	wire btn_start = i_joy_a[ctrl_pkg::JOY_START] | i_joy_b[ctrl_pkg::JOY_START] | i_key_start;

	// Difficulty buttons act as toggles
	always_ff @(posedge clk_sys) begin
		old_diff_r <= btn_diff_r;
		old_diff_l <= btn_diff_l;
		if (reset) begin
			diff_r <= 1'b0;
			diff_l <= 1'b0;
		end else begin
			if (btn_diff_r && !old_diff_r)
				diff_r <= ~diff_r;
			if (btn_diff_l && !old_diff_l)
				diff_l <= ~diff_l;
		end
	end

	assign o_pb_in = {
		~diff_r,      // Right difficulty
		~diff_l,      // Left difficulty
		i_pb_out[5:4],
		~btn_pause,
		i_pb_out[2],  // Two button sense line, looped back
		~btn_select,
		~btn_start
	};

endmodule

`default_nettype wire

//--- verilog/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// Host joystick word, one bit per button, active high
	typedef logic [15:0] joy_t;

	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE1  = 4;
	localparam int JOY_FIRE2  = 5;
	localparam int JOY_PAUSE  = 6;
	localparam int JOY_SELECT = 7;
	localparam int JOY_START  = 8;
	localparam int JOY_DIFF_L = 10;
	localparam int JOY_DIFF_R = 11;

	typedef logic [10:0] ps2_key_t;   // {toggle, pressed, code[8:0]}
	typedef logic [24:0] ps2_mouse_t; // {toggle, y, x, flags}
	typedef logic [7:0]  riot_port_t;
	typedef logic [3:0]  nibble_t;
	typedef logic [2:0]  keypad_t;    // {latch, dump[1:0]}

	typedef enum logic [1:0] {
		PORT_NONE,
		PORT_JOYSTICK,
		PORT_TRACKBALL,
		PORT_KEYPAD
	} port_type_e;

	// Set 2 scan codes, number row
	localparam logic [8:0] SC_1     = 9'h016;
	localparam logic [8:0] SC_2     = 9'h01e;
	localparam logic [8:0] SC_3     = 9'h026;
	localparam logic [8:0] SC_4     = 9'h025;
	localparam logic [8:0] SC_5     = 9'h02e;
	localparam logic [8:0] SC_6     = 9'h036;
	localparam logic [8:0] SC_7     = 9'h03d;
	localparam logic [8:0] SC_8     = 9'h03e;
	localparam logic [8:0] SC_9     = 9'h046;
	localparam logic [8:0] SC_0     = 9'h045;
	localparam logic [8:0] SC_MINUS = 9'h04e;
	localparam logic [8:0] SC_EQUAL = 9'h055;
	localparam logic [8:0] SC_F1    = 9'h005; // Select
	localparam logic [8:0] SC_F2    = 9'h006; // Start

endpackage

`default_nettype wire

//--- verilog/ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_top (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire ctrl_pkg::joy_t       i_joy_a,
	input  wire ctrl_pkg::joy_t       i_joy_b,
	input  wire ctrl_pkg::ps2_key_t   i_ps2_key,
	input  wire ctrl_pkg::ps2_mouse_t i_ps2_mouse,
	input  wire ctrl_pkg::port_type_e i_porta_type,
	input  wire ctrl_pkg::port_type_e i_portb_type,
	input  wire ctrl_pkg::riot_port_t i_pa_out,
	input  wire ctrl_pkg::riot_port_t i_pb_out,
	input  wire                       i_pa_read,
	output ctrl_pkg::riot_port_t      o_pa_in,
	output ctrl_pkg::riot_port_t      o_pb_in,
	output logic [1:0]                o_ilatch,
	output logic [3:0]                o_idump
);

	ctrl_pkg::keypad_t keypad_a;
	ctrl_pkg::keypad_t keypad_b;
	ctrl_pkg::nibble_t trackball;
	logic trackball_button;
	logic key_start, key_select; // F2, F1

	keypad_matrix u_keypad_matrix (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.i_ps2_key    (i_ps2_key),
		.i_pa_out     (i_pa_out),
		.o_keypad_a   (keypad_a),
		.o_keypad_b   (keypad_b),
		.o_key_start  (key_start),
		.o_key_select (key_select)
	);

	trackball_feed u_trackball_feed (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.i_ps2_mouse (i_ps2_mouse),
		.i_pa_read   (i_pa_read),
		.o_trackball (trackball),
		.o_button    (trackball_button)
	);

	console_switches u_console_switches (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.i_joy_a      (i_joy_a),
		.i_joy_b      (i_joy_b),
		.i_key_start  (key_start),
		.i_key_select (key_select),
		.i_pb_out     (i_pb_out),
		.o_pb_in      (o_pb_in)
	);

	port_mux u_port_mux (
		.i_porta_type       (i_porta_type),
		.i_portb_type       (i_portb_type),
		.i_joy_a            (i_joy_a),
		.i_joy_b            (i_joy_b),
		.i_pa_out           (i_pa_out),
		.i_keypad_a         (keypad_a),
		.i_keypad_b         (keypad_b),
		.i_trackball        (trackball),
		.i_trackball_button (trackball_button),
		.o_pa_in            (o_pa_in),
		.o_ilatch           (o_ilatch),
		.o_idump            (o_idump)
	);

endmodule

`default_nettype wire

//--- verilog/keypad_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_matrix (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire ctrl_pkg::ps2_key_t   i_ps2_key,
	input  wire ctrl_pkg::riot_port_t i_pa_out,
	output ctrl_pkg::keypad_t     o_keypad_a,
	output ctrl_pkg::keypad_t     o_keypad_b,
	output logic                  o_key_start,
	output logic                  o_key_select
);

	logic last_toggle;
	logic [11:0] key_held; // Bit row*3 + col
	ctrl_pkg::keypad_t sense_a;
	ctrl_pkg::keypad_t sense_b;

	wire key_event = last_toggle != i_ps2_key[10];
	wire key_pressed = i_ps2_key[9];
	wire [8:0] scan_code = i_ps2_key[8:0];

	// Held key state, one event per toggle change
	always_ff @(posedge clk_sys) begin
		last_toggle <= i_ps2_key[10];
		if (reset) begin
			key_held <= '0;
			o_key_start <= 1'b0;
			o_key_select <= 1'b0;
		end else if (key_event) begin
			case (scan_code)
				ctrl_pkg::SC_1:     key_held[0] <= key_pressed; // Row 0
				ctrl_pkg::SC_2:     key_held[1] <= key_pressed;
				ctrl_pkg::SC_3:     key_held[2] <= key_pressed;
				ctrl_pkg::SC_4:     key_held[3] <= key_pressed; // Row 1
				ctrl_pkg::SC_5:     key_held[4] <= key_pressed;
				ctrl_pkg::SC_6:     key_held[5] <= key_pressed;
				ctrl_pkg::SC_7:     key_held[6] <= key_pressed; // Row 2
				ctrl_pkg::SC_8:     key_held[7] <= key_pressed;
				ctrl_pkg::SC_9:     key_held[8] <= key_pressed;
				ctrl_pkg::SC_MINUS: key_held[9] <= key_pressed; // Row 3
				ctrl_pkg::SC_0:     key_held[10] <= key_pressed;
				ctrl_pkg::SC_EQUAL: key_held[11] <= key_pressed;
				ctrl_pkg::SC_F1:    o_key_select <= key_pressed;
				ctrl_pkg::SC_F2:    o_key_start <= key_pressed;
				default: ;
			endcase
		end
	end

	// Column lines are pulled up; a held key shorts its column to the row line.
	// Rows scanned 0 to 3 so the later row wins on a shared column
	always_comb begin
		sense_a = '1;
		sense_b = '1;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (key_held[r * 3 + c]) begin
					sense_a[c] = i_pa_out[4 + r]; // Port A rows on PA7..4
					sense_b[c] = i_pa_out[r];
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_keypad_a <= '1;
			o_keypad_b <= '1;
		end else begin
			o_keypad_a <= sense_a;
			o_keypad_b <= sense_b;
		end
	end

endmodule

`default_nettype wire

//--- verilog/port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module port_mux (
	input  wire ctrl_pkg::port_type_e i_porta_type,
	input  wire ctrl_pkg::port_type_e i_portb_type,
	input  wire ctrl_pkg::joy_t       i_joy_a,
	input  wire ctrl_pkg::joy_t       i_joy_b,
	input  wire ctrl_pkg::riot_port_t i_pa_out,
	input  wire ctrl_pkg::keypad_t    i_keypad_a,
	input  wire ctrl_pkg::keypad_t    i_keypad_b,
	input  wire ctrl_pkg::nibble_t    i_trackball,
	input  wire                       i_trackball_button,
	output ctrl_pkg::riot_port_t      o_pa_in,
	output logic [1:0]                o_ilatch,
	output logic [3:0]                o_idump
);

	ctrl_pkg::port_type_e type_b;
	logic [6:0] half_a, half_b; // {latch, dump[1:0], nibble[3:0]}

	// Input rule for one controller port
	function automatic logic [6:0] half_rule(
		input ctrl_pkg::port_type_e kind,
		input ctrl_pkg::joy_t       joy,
		input ctrl_pkg::nibble_t    pa_half,
		input ctrl_pkg::keypad_t    keypad,
		input ctrl_pkg::nibble_t    ball,
		input logic                 ball_button
	);
		logic fire1;
		logic fire2;
		logic [6:0] result;
		fire1 = joy[ctrl_pkg::JOY_FIRE1];
		fire2 = joy[ctrl_pkg::JOY_FIRE2];
		result = {1'b1, 2'b00, 4'b1111}; // Nothing plugged in
		case (kind)
			ctrl_pkg::PORT_JOYSTICK: begin
				result = {~(fire1 | fire2), fire1, fire2,
					~joy[ctrl_pkg::JOY_RIGHT], ~joy[ctrl_pkg::JOY_LEFT],
					~joy[ctrl_pkg::JOY_DOWN], ~joy[ctrl_pkg::JOY_UP]};
			end
			ctrl_pkg::PORT_TRACKBALL: result = {~ball_button, 2'b00, ball};
			ctrl_pkg::PORT_KEYPAD:    result = {keypad, pa_half}; // Rows read back
			default: ;
		endcase
		return result;
	endfunction

	// Only one trackball feed, port A keeps it
	always_comb begin
		type_b = i_portb_type;
		if (i_portb_type == ctrl_pkg::PORT_TRACKBALL && i_porta_type == ctrl_pkg::PORT_TRACKBALL)
			type_b = ctrl_pkg::PORT_JOYSTICK;
	end

	assign half_a = half_rule(i_porta_type, i_joy_a, i_pa_out[7:4], i_keypad_a,
		i_trackball, i_trackball_button);
	assign half_b = half_rule(type_b, i_joy_b, i_pa_out[3:0], i_keypad_b,
		i_trackball, i_trackball_button);

	assign o_pa_in = {half_a[3:0], half_b[3:0]};
	assign o_ilatch = {half_b[6], half_a[6]};
	assign o_idump = {half_b[5:4], half_a[5:4]};

endmodule

`default_nettype wire

//--- verilog/trackball_feed.sv
`timescale 1ns/1ps
`default_nettype none

module trackball_feed (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire ctrl_pkg::ps2_mouse_t i_ps2_mouse,
	input  wire                     i_pa_read,
	output ctrl_pkg::nibble_t       o_trackball,
	output logic                    o_button
);

	logic last_toggle;
	logic [7:0] count_x, count_y; // Pending steps per axis
	logic dir_x, dir_y;
	logic tog_x, tog_y;

	wire packet = last_toggle != i_ps2_mouse[24];
	wire sign_x = i_ps2_mouse[4];
	wire sign_y = i_ps2_mouse[5];

	always_ff @(posedge clk_sys) begin
		last_toggle <= i_ps2_mouse[24];
		if (reset) begin
			count_x <= '0;
			count_y <= '0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
			tog_x <= 1'b0;
			tog_y <= 1'b0;
			o_trackball <= '0;
			o_button <= 1'b0;
		end else if (packet) begin
			// Magnitude by one's complement of negative counts
			count_x <= sign_x ? ~i_ps2_mouse[15:8] : i_ps2_mouse[15:8];
			count_y <= sign_y ? ~i_ps2_mouse[23:16] : i_ps2_mouse[23:16];
			dir_x <= ~sign_x; // X runs the other way on the trackball
			dir_y <= sign_y;
			o_button <= i_ps2_mouse[1] | i_ps2_mouse[0];
		end else if (i_pa_read) begin
			// One step per port A read
			o_trackball <= {tog_y, dir_y, tog_x, dir_x};
			if (count_y != 8'd0) begin
				count_y <= count_y - 8'd1;
				tog_y <= ~tog_y;
			end
			if (count_x != 8'd0) begin
				count_x <= count_x - 8'd1;
				tog_x <= ~tog_x;
			end
		end
	end

endmodule

`default_nettype wire
